// File: player_cfg_pkg.sv
package player_cfg_pkg;

  // ====================
  // Audio samples
  // ====================

  localparam int sample_w = 16;

  // ====================
  // Speed control
  // ====================

  // Six hex digits of divisor
  localparam int divisor_w = 24;

  // Roughly 44 kHz out of 50 MHz
  localparam int unsigned default_divisor = 1136;
  localparam int unsigned divisor_step = 100;
  localparam int unsigned min_divisor = 200;

  // Largest value the divisor register can hold
  localparam logic [divisor_w-1:0] max_divisor = '1;

  // Ten steps a second while a key stays down
  localparam int unsigned key_repeat_cycles = 5_000_000;

  // ====================
  // Seven-segment display
  // ====================

  localparam int num_digits = 6;
  // gfedcba, active low
  localparam int seg_w = 7;

endpackage

// File: flash_bus_pkg.sv
package flash_bus_pkg;

  // ====================
  // Flash port
  // ====================

  localparam int flash_addr_w = 23;
  localparam int flash_data_w = 32;

  // ====================
  // Word layout
  // ====================

  // Low half plays first, then high half
  localparam int samples_per_word = 2;

  // End of the song, wraps back to word 0
  localparam logic [flash_addr_w-1:0] last_word_addr = 23'h7_FFFF;

endpackage

// File: speed_key_conditioner.sv
`timescale 1ns/1ps

module speed_key_conditioner
  import player_cfg_pkg::*;
#(
  parameter int unsigned repeat_cycles = key_repeat_cycles
)
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic [2:0] key,
  output logic       speed_up,
  output logic       speed_down,
  output logic       speed_reset
);

  localparam int cnt_w = (repeat_cycles > 1) ? $clog2(repeat_cycles) : 1;

  logic [2:0]       key_meta;
  logic [2:0]       key_pressed;
  logic [cnt_w-1:0] repeat_count;
  logic             repeat_wrap;

  // Keys are active low, flip them on entry so 1 means pressed
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta    <= 3'b000;
      key_pressed <= 3'b000;
    end
    else
    begin
      key_meta    <= ~key;
      key_pressed <= key_meta;
    end
  end

  // Free-running repeat interval
  assign repeat_wrap = (repeat_count == cnt_w'(repeat_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (rst || repeat_wrap)
      repeat_count <= '0;
    else
      repeat_count <= repeat_count + 1'b1;
  end

  // One step per wrap for each held key
  assign speed_up    = repeat_wrap & key_pressed[0];
  assign speed_down  = repeat_wrap & key_pressed[1];
  assign speed_reset = key_pressed[2];

  a_up_one_cycle: assert property (@(posedge CLK_50M) disable iff (rst)
    speed_up |=> !speed_up);

  a_down_one_cycle: assert property (@(posedge CLK_50M) disable iff (rst)
    speed_down |=> !speed_down);

endmodule

// File: sample_rate_ctrl.sv
`timescale 1ns/1ps

module sample_rate_ctrl
  import player_cfg_pkg::*;
#(
  parameter int unsigned default_div = default_divisor,
  parameter int unsigned step        = divisor_step,
  parameter int unsigned min_div     = min_divisor
)
(
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  logic                 speed_up,
  input  logic                 speed_down,
  input  logic                 speed_reset,
  output logic [divisor_w-1:0] divisor,
  output logic                 sample_tick
);

  logic [divisor_w-1:0] div_faster;
  logic [divisor_w-1:0] div_slower;
  logic [divisor_w-1:0] tick_count;

  // ====================
  // Divisor update
  // ====================

  // Clamped neighbours of the current divisor
  assign div_faster = (divisor < min_div + step) ? divisor_w'(min_div)
                                                 : divisor - divisor_w'(step);
  assign div_slower = (divisor > max_divisor - step) ? max_divisor
                                                     : divisor + divisor_w'(step);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      divisor <= divisor_w'(default_div);
    else if (speed_reset)
      divisor <= divisor_w'(default_div);
    else if (speed_up && !speed_down)
      divisor <= div_faster;
    else if (speed_down && !speed_up)
      divisor <= div_slower;
    // both at once cancel out
  end

  // ====================
  // Sample tick divider
  // ====================

  // Also catches a divisor that just shrank below the count
  assign sample_tick = (tick_count >= divisor - 1'b1);

  always_ff @(posedge CLK_50M)
  begin
    if (rst || sample_tick)
      tick_count <= '0;
    else
      tick_count <= tick_count + 1'b1;
  end

  // Upper bound is the full register range
  a_divisor_bounds: assert property (@(posedge CLK_50M) disable iff (rst)
    divisor >= min_div);

endmodule

// File: flash_sample_reader.sv
`timescale 1ns/1ps

module flash_sample_reader
  import player_cfg_pkg::*, flash_bus_pkg::*;
#(
  parameter logic [flash_addr_w-1:0] last_addr = last_word_addr
)
(
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    sample_tick,
  output logic                    flash_read,
  output logic [flash_addr_w-1:0] flash_address,
  input  logic                    flash_waitrequest,
  input  logic [flash_data_w-1:0] flash_readdata,
  input  logic                    flash_readdatavalid,
  output logic [sample_w-1:0]     sample,
  output logic                    sample_valid
);

  localparam int half_w = (samples_per_word > 1) ? $clog2(samples_per_word) : 1;

  logic                    req_accept;
  logic                    req_pending;
  logic                    buf_valid;
  logic [flash_data_w-1:0] buf_word;
  logic                    cur_valid;
  logic [flash_data_w-1:0] cur_word;
  logic [half_w-1:0]       half_sel;
  logic                    last_half;
  logic                    load_cur;
  logic                    play;

  assign req_accept = flash_read && !flash_waitrequest;
  assign load_cur   = buf_valid && !cur_valid;
  assign play       = sample_tick && cur_valid;
  assign last_half  = (half_sel == half_w'(samples_per_word - 1));

  // ====================
  // Fetch stage
  // ====================

  // One request at a time, only into an empty prefetch buffer
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      flash_read    <= 1'b0;
      flash_address <= '0;
      req_pending   <= 1'b0;
    end
    else
    begin
      if (req_accept)
      begin
        flash_read    <= 1'b0;
        flash_address <= (flash_address == last_addr) ? '0 : flash_address + 1'b1;
      end
      else if (!flash_read && !req_pending && !buf_valid)
        flash_read <= 1'b1;

      if (req_accept)
        req_pending <= 1'b1;
      else if (flash_readdatavalid)
        req_pending <= 1'b0;
    end
  end

  // ====================
  // Play stage
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      buf_valid    <= 1'b0;
      cur_valid    <= 1'b0;
      half_sel     <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= play;
      if (flash_readdatavalid)
        buf_valid <= 1'b1;
      else if (load_cur)
        buf_valid <= 1'b0;

      if (load_cur)
      begin
        cur_valid <= 1'b1;
        half_sel  <= '0;
      end
      else if (play)
      begin
        half_sel <= last_half ? '0 : half_sel + 1'b1;
        if (last_half)
          cur_valid <= 1'b0;
      end
    end
  end

  // Word and sample data
  always_ff @(posedge CLK_50M)
  begin
    if (flash_readdatavalid)
      buf_word <= flash_readdata;
    if (load_cur)
      cur_word <= buf_word;
    if (play)
      sample <= cur_word[sample_w*half_sel +: sample_w];
  end

  a_stall_stable: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address));

  a_no_stray_data: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_readdatavalid |-> req_pending);

endmodule

// File: hex_speed_display.sv
`timescale 1ns/1ps

module hex_speed_display
  import player_cfg_pkg::*;
(
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  logic [divisor_w-1:0] divisor,
  output logic [seg_w-1:0]     hex0,
  output logic [seg_w-1:0]     hex1,
  output logic [seg_w-1:0]     hex2,
  output logic [seg_w-1:0]     hex3,
  output logic [seg_w-1:0]     hex4,
  output logic [seg_w-1:0]     hex5
);

  logic [3:0]       digit [num_digits];
  logic [seg_w-1:0] seg   [num_digits];

  // Lit segments in gfedcba order, inverted for the board
  function automatic logic [seg_w-1:0] hex_to_seg(input logic [3:0] value);
    logic [seg_w-1:0] lit;
    case (value)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // Digit 0 is the least significant nibble
  for (genvar i = 0; i < num_digits; i++)
  begin : g_digit
    always_ff @(posedge CLK_50M)
    begin
      if (rst)
        digit[i] <= 4'h0;
      else
        digit[i] <= divisor[4*i +: 4];
    end

    assign seg[i] = hex_to_seg(digit[i]);
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

// File: ipod_player_top.sv
`timescale 1ns/1ps

module ipod_player_top
  import player_cfg_pkg::*, flash_bus_pkg::*;
#(
  parameter int unsigned repeat_cycles = key_repeat_cycles,
  parameter int unsigned default_div   = default_divisor,
  parameter int unsigned step          = divisor_step,
  parameter int unsigned min_div       = min_divisor,
  parameter logic [flash_addr_w-1:0] last_addr = last_word_addr
)
(
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic [2:0]              key,
  output logic                    flash_read,
  output logic [flash_addr_w-1:0] flash_address,
  input  logic                    flash_waitrequest,
  input  logic [flash_data_w-1:0] flash_readdata,
  input  logic                    flash_readdatavalid,
  output logic [sample_w-1:0]     sample,
  output logic                    sample_valid,
  output logic [seg_w-1:0]        hex0,
  output logic [seg_w-1:0]        hex1,
  output logic [seg_w-1:0]        hex2,
  output logic [seg_w-1:0]        hex3,
  output logic [seg_w-1:0]        hex4,
  output logic [seg_w-1:0]        hex5
);

  logic                 speed_up;
  logic                 speed_down;
  logic                 speed_reset;
  logic [divisor_w-1:0] divisor;
  logic                 sample_tick;

  // ====================
  // Speed keys and rate
  // ====================

  speed_key_conditioner #(
    .repeat_cycles (repeat_cycles)
  ) u_speed_key_conditioner (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .key         (key),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset)
  );

  sample_rate_ctrl #(
    .default_div (default_div),
    .step        (step),
    .min_div     (min_div)
  ) u_sample_rate_ctrl (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divisor     (divisor),
    .sample_tick (sample_tick)
  );

  // ====================
  // Playback and display
  // ====================

  flash_sample_reader #(
    .last_addr (last_addr)
  ) u_flash_sample_reader (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .sample_tick         (sample_tick),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid)
  );

  hex_speed_display u_hex_speed_display (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .divisor (divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

// File: tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model
  import flash_bus_pkg::*;
#(
  parameter int depth     = 8,
  parameter int seed_init = 1
)
(
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    flash_read,
  input  logic [flash_addr_w-1:0] flash_address,
  output logic                    flash_waitrequest,
  output logic [flash_data_w-1:0] flash_readdata,
  output logic                    flash_readdatavalid
);

  logic [flash_data_w-1:0] mem [depth];
  logic [flash_data_w-1:0] data_q [$];
  int                      due_q [$];
  integer                  seed;
  int                      cycle;
  int                      wait_left;
  int                      last_due;
  int                      due;
  logic                    in_reset;
  logic                    accepted;
  logic                    stalled;
  logic [flash_addr_w-1:0] addr_seen;

  function automatic int pick_between(input int lo, input int hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  initial
  begin
    seed                = seed_init;
    cycle               = 0;
    last_due            = 0;
    wait_left           = pick_between(0, 3);
    flash_waitrequest   = (wait_left != 0);
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
  end

  // Bus values are settled at the falling edge, act on them after the rising edge
  always
  begin
    @(negedge CLK_50M);
    in_reset  = rst;
    accepted  = flash_read && !flash_waitrequest;
    stalled   = flash_read && flash_waitrequest;
    addr_seen = flash_address;
    @(posedge CLK_50M);
    #2;
    cycle = cycle + 1;
    if (in_reset)
    begin
      data_q.delete();
      due_q.delete();
      last_due            = 0;
      flash_readdatavalid = 1'b0;
    end
    else
    begin
      if (stalled)
        wait_left--;
      if (accepted)
      begin
        // Latency 1 means data in the very next cycle
        due = cycle + pick_between(1, 4) - 1;
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        // Reads past the end of the song return unknown data
        data_q.push_back(mem[addr_seen]);
        due_q.push_back(due);
        wait_left = pick_between(0, 3);
      end
      if (due_q.size() > 0 && due_q[0] == cycle)
      begin
        flash_readdata      = data_q.pop_front();
        flash_readdatavalid = 1'b1;
        void'(due_q.pop_front());
      end
      else
        flash_readdatavalid = 1'b0;
    end
    flash_waitrequest = (wait_left != 0);
  end

endmodule

// File: tb_ipod_player.sv
`timescale 1ns/1ps

module tb_ipod_player
  import player_cfg_pkg::*, flash_bus_pkg::*;
  ;

  // Shortened timing for simulation
  localparam int t_repeat = 16;
  localparam int t_div    = 40;
  localparam int t_step   = 4;
  localparam int t_min    = 20;
  localparam logic [flash_addr_w-1:0] t_last = 7;
  localparam int song_words = 8;
  localparam int seed_value = 67073;

  // Test lengths in cycles
  localparam int idle_cycles    = 700;
  localparam int num_holds      = 8;
  localparam int max_hold       = 70;
  localparam int max_gap        = 40;
  localparam int clamp_cycles   = 900;
  localparam int settle_cycles  = 100;
  localparam int restore_hold   = 10;
  localparam int restore_cycles = 200;
  localparam int test_cycles = 4 + idle_cycles + num_holds * (max_hold + max_gap)
                             + clamp_cycles + settle_cycles + restore_hold + restore_cycles;
  localparam int cycle_limit = 2 * test_cycles;

  logic                    CLK_50M = 1'b0;
  logic                    rst;
  logic [2:0]              key;
  logic                    flash_read;
  logic [flash_addr_w-1:0] flash_address;
  logic                    flash_waitrequest;
  logic [flash_data_w-1:0] flash_readdata;
  logic                    flash_readdatavalid;
  logic [sample_w-1:0]     sample;
  logic                    sample_valid;
  logic [seg_w-1:0]        hex0;
  logic [seg_w-1:0]        hex1;
  logic [seg_w-1:0]        hex2;
  logic [seg_w-1:0]        hex3;
  logic [seg_w-1:0]        hex4;
  logic [seg_w-1:0]        hex5;

  integer                  seed;
  logic [flash_data_w-1:0] song [song_words];
  int                      errors = 0;
  int                      cycles = 0;
  int                      sample_idx = 0;
  logic [sample_w-1:0]     want_sample;

  // Reference model state
  logic [2:0] m_sync1;
  logic [2:0] m_sync2;
  int         m_rep;
  int         m_div;
  int         m_disp;
  int         m_tick_cnt;
  logic       m_valid;
  logic       m_tick;
  logic       m_up;
  logic       m_down;
  int         post_rst = 0;

  always #10 CLK_50M = ~CLK_50M;

  ipod_player_top #(
    .repeat_cycles (t_repeat),
    .default_div   (t_div),
    .step          (t_step),
    .min_div       (t_min),
    .last_addr     (t_last)
  ) u_ipod_player_top (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .key                 (key),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  tb_flash_model #(
    .depth     (song_words),
    .seed_init (seed_value)
  ) u_flash_model (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  // ====================
  // Helpers
  // ====================

  function automatic int pick_between(input int lo, input int hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Active-low segments, gfedcba
  function automatic logic [seg_w-1:0] seg_for(input logic [3:0] nibble);
    logic [seg_w-1:0] on;
    case (nibble)
      4'h0: on = 7'b0111111;
      4'h1: on = 7'b0000110;
      4'h2: on = 7'b1011011;
      4'h3: on = 7'b1001111;
      4'h4: on = 7'b1100110;
      4'h5: on = 7'b1101101;
      4'h6: on = 7'b1111101;
      4'h7: on = 7'b0000111;
      4'h8: on = 7'b1111111;
      4'h9: on = 7'b1101111;
      4'hA: on = 7'b1110111;
      4'hB: on = 7'b1111100;
      4'hC: on = 7'b0111001;
      4'hD: on = 7'b1011110;
      4'hE: on = 7'b1111001;
      default: on = 7'b1110001;
    endcase
    return ~on;
  endfunction

  // Low half of each word first, song wraps after the last word
  function automatic logic [sample_w-1:0] expected_sample(input int idx);
    int word;
    int half;
    word = (idx / samples_per_word) % song_words;
    half = idx % samples_per_word;
    return song[word][sample_w*half +: sample_w];
  endfunction

  task automatic check_display(input logic [divisor_w-1:0] value);
    logic [num_digits*seg_w-1:0] want;
    logic [num_digits*seg_w-1:0] got;
    for (int i = 0; i < num_digits; i++)
      want[seg_w*i +: seg_w] = seg_for(value[4*i +: 4]);
    got = {hex5, hex4, hex3, hex2, hex1, hex0};
    assert (got === want)
    else
    begin
      errors++;
      $display("error at %0t: display %h does not show divisor %h", $time, got, value);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK_50M);
    #2;
  endtask

  task automatic hold_key(input int idx, input int len);
    key[idx] = 1'b0;
    wait_cycles(len);
    key[idx] = 1'b1;
  endtask

  // ====================
  // Reference model
  // ====================

  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      m_sync1    = 3'b000;
      m_sync2    = 3'b000;
      m_rep      = 0;
      m_div      = t_div;
      m_disp     = 0;
      m_tick_cnt = 0;
      m_valid    = 1'b0;
      post_rst   = 0;
    end
    else
    begin
      // Tick on the last count, or past it after the divisor shrank
      m_tick     = (m_tick_cnt >= m_div - 1);
      m_up       = (m_rep == t_repeat - 1) && m_sync2[0];
      m_down     = (m_rep == t_repeat - 1) && m_sync2[1];
      m_valid    = m_tick;
      m_disp     = m_div;
      m_tick_cnt = m_tick ? 0 : m_tick_cnt + 1;
      m_rep      = (m_rep == t_repeat - 1) ? 0 : m_rep + 1;
      if (m_sync2[2])
        m_div = t_div;
      else if (m_up && !m_down)
        m_div = (m_div - t_step < t_min) ? t_min : m_div - t_step;
      else if (m_down && !m_up)
        m_div = (m_div + t_step > int'(max_divisor)) ? int'(max_divisor) : m_div + t_step;
      m_sync2  = m_sync1;
      m_sync1  = ~key;
      post_rst = post_rst + 1;
    end
  end

  // Outputs are compared mid-cycle, well away from the clock edge
  always @(negedge CLK_50M)
  begin
    if (!rst && post_rst > 0)
    begin
      check_display(m_disp);
      assert (sample_valid === m_valid)
      else
      begin
        errors++;
        $display("error at %0t: sample_valid %b, expected %b", $time, sample_valid, m_valid);
      end
      if (sample_valid === 1'b1 && m_valid)
      begin
        want_sample = expected_sample(sample_idx);
        assert (sample === want_sample)
        else
        begin
          errors++;
          $display("error at %0t: sample %0d is %h, expected %h",
                   $time, sample_idx, sample, want_sample);
        end
        sample_idx++;
      end
      if (post_rst == 1)
      begin
        assert (flash_read === 1'b1)
        else
        begin
          errors++;
          $display("error at %0t: no flash read on the first cycle after reset", $time);
        end
      end
    end
  end

  // ====================
  // Stimulus
  // ====================

  initial
  begin
    rst  = 1'b1;
    key  = 3'b111;
    seed = seed_value;
    for (int i = 0; i < song_words; i++)
    begin
      song[i] = $random(seed);
      u_flash_model.mem[i] = song[i];
    end
    wait_cycles(4);
    rst = 1'b0;

    // Idle playback through at least one song wrap
    wait_cycles(idle_cycles);

    // Random speed up and slow down holds
    for (int n = 0; n < num_holds; n++)
    begin
      hold_key(pick_between(0, 1), pick_between(10, max_hold - 1));
      wait_cycles(pick_between(5, max_gap - 1));
    end

    // Long hold down to the lower clamp, then restore
    hold_key(0, clamp_cycles);
    wait_cycles(settle_cycles);
    check_display(t_min);
    hold_key(2, restore_hold);
    wait_cycles(restore_cycles);
    check_display(t_div);

    assert (sample_idx > samples_per_word * song_words)
    else
    begin
      errors++;
      $display("Too few samples were played to cover the song wrap: %0d", sample_idx);
    end

    $display("Run finished with %0d errors", errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  always @(posedge CLK_50M)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout: the run was still going after %0d cycles", cycles);
      $display("Run stopped with %0d errors", errors);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

// File: build.f
player_cfg_pkg.sv
flash_bus_pkg.sv
speed_key_conditioner.sv
sample_rate_ctrl.sv
flash_sample_reader.sv
hex_speed_display.sv
ipod_player_top.sv
tb_flash_model.sv
tb_ipod_player.sv
